// ==== ctrl_pkg.sv ====
package ctrl_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////

  // interrupt id width, fixed by the interrupt controller
  localparam int unsigned IRQ_ID_W = 5;

  //////////////////////////////
  // controller state
  //////////////////////////////

  // main controller states, debug states removed
  typedef enum logic [3:0] {
    RESET,
    BOOT_SET,
    WAIT_SLEEP,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    FLUSH,
    IRQ_TAKEN
  } ctrl_state_e;

  //////////////////////////////
  // decoder view
  //////////////////////////////

  // raw levels from the decoder and the id stage
  typedef struct packed {
    logic valid;        // instruction in id is valid
    logic illegal;      // decoder saw an illegal encoding
    logic ecall;
    logic mret;
    logic pipe_flush;   // fence / wfi style flush request
    logic branch_set;   // branch taken, target ready
    logic jump_set;     // jump target ready
    logic branch_in_id;
    logic multicycle;   // id holds a multicycle operation
  } insn_flags_t;

  // one event per instruction after priority resolution
  typedef enum logic [2:0] {
    EV_NONE,
    EV_BRANCH,
    EV_JUMP,
    EV_ECALL,
    EV_ILLEGAL,
    EV_MRET,
    EV_FLUSH
  } insn_event_e;

  // request from the interrupt controller
  typedef struct packed {
    logic                req;
    logic [IRQ_ID_W-1:0] id;
  } irq_req_t;

endpackage

// ==== trap_pkg.sv ====
package trap_pkg;

  //////////////////////////////
  // cause codes
  //////////////////////////////

  // mcause width, top bit marks an interrupt
  localparam int unsigned CAUSE_W = 6;

  // synchronous exception codes from the privileged spec
  localparam logic [CAUSE_W-1:0] EXC_CAUSE_ILLEGAL_INSN = 6'd2;
  localparam logic [CAUSE_W-1:0] EXC_CAUSE_ECALL_MMODE  = 6'd11;

  //////////////////////////////
  // pc selection
  //////////////////////////////

  // fetch stage pc source
  // encodings match the if stage mux
  typedef enum logic [2:0] {
    PC_BOOT      = 3'b000,
    PC_JUMP      = 3'b010,
    PC_EXCEPTION = 3'b100,
    PC_ERET      = 3'b101
  } pc_mux_e;

  // vector offset select inside the exception table
  typedef enum logic [1:0] {
    EXC_PC_ILLINSN = 2'b00,
    EXC_PC_ECALL   = 2'b01,
    EXC_PC_IRQ     = 2'b11
  } exc_pc_e;

  //////////////////////////////
  // controller outputs
  //////////////////////////////

  // pc redirect towards the fetch stage
  typedef struct packed {
    logic    set;      // load new pc this cycle
    pc_mux_e mux;
    exc_pc_e exc_mux;  // only meaningful with PC_EXCEPTION
  } pc_req_t;

  // csr save / restore strobes
  typedef struct packed {
    logic               save_if;       // mepc from if stage pc
    logic               save_id;       // mepc from id stage pc
    logic               save_cause;
    logic               restore_mret;  // pop mstatus on mret
    logic [CAUSE_W-1:0] cause;
  } csr_ctrl_t;

endpackage

// ==== insn_event_sel.sv ====
`timescale 1ns/100ps

module insn_event_sel (
  input  ctrl_pkg::insn_flags_t insn_i,
  output ctrl_pkg::insn_event_e ev_o
);

  import ctrl_pkg::*;

  //////////////////////////////
  // event priority
  //////////////////////////////

  // decoder flags may overlap, e.g. illegal together with mret
  // first match wins, so fsm and trap unit see the same event
  always_comb begin
    ev_o = EV_NONE;
    if (insn_i.valid) begin
      if (insn_i.branch_set) begin
        ev_o = EV_BRANCH;
      end else if (insn_i.jump_set) begin
        ev_o = EV_JUMP;
      end else if (insn_i.ecall) begin
        ev_o = EV_ECALL;
      end else if (insn_i.illegal) begin
        ev_o = EV_ILLEGAL;
      end else if (insn_i.mret) begin
        ev_o = EV_MRET;
      end else if (insn_i.pipe_flush) begin
        ev_o = EV_FLUSH;
      end else begin
        // plain instruction, nothing special
        ev_o = EV_NONE;
      end
    end
    // invalid slot always maps to EV_NONE
  end

endmodule

// ==== ctrl_fsm.sv ====
`timescale 1ns/100ps

module ctrl_fsm (
  input  logic                            clk,
  input  logic                            rst_n,

  input  logic                            fetch_enable_i,
  input  logic                            id_ready_i,
  input  logic                            m_ie_i,
  input  logic                            instr_valid_i,
  input  ctrl_pkg::insn_event_e           ev_i,
  input  ctrl_pkg::irq_req_t              irq_i,
  input  logic                            branch_in_id_i,
  input  logic                            multicycle_i,

  output ctrl_pkg::ctrl_state_e           state_o,
  output logic                            ctrl_busy_o,
  output logic                            instr_req_o,
  output logic                            first_fetch_o,
  output logic                            is_decoding_o,
  output logic                            halt_if_o,
  output logic                            halt_id_o,
  output logic                            deassert_we_o,
  output logic                            irq_ack_o,
  output logic                            exc_kill_o,
  output logic [ctrl_pkg::IRQ_ID_W-1:0]   irq_id_o
);

  import ctrl_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // interrupt pending and allowed by mstatus.mie
  logic irq_pending;
  // id stage can be abandoned without losing work
  logic irq_safe;

  assign irq_pending = irq_i.req & m_ie_i;
  assign irq_safe    = ~multicycle_i & ~branch_in_id_i;

  //////////////////////////////
  // next state and levels
  //////////////////////////////

  always_comb begin
    state_d       = state_q;
    ctrl_busy_o   = 1'b1;
    instr_req_o   = 1'b1;
    first_fetch_o = 1'b0;
    is_decoding_o = 1'b0;
    halt_if_o     = 1'b0;
    halt_id_o     = 1'b0;
    irq_ack_o     = 1'b0;
    exc_kill_o    = 1'b0;

    unique case (state_q)
      // idle after reset until fetch is enabled
      RESET: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        if (fetch_enable_i) begin
          state_d = BOOT_SET;
        end
      end

      // boot address is loaded by the trap unit here
      BOOT_SET: begin
        state_d = FIRST_FETCH;
      end

      // one cycle to let the pipe drain before sleeping
      WAIT_SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        state_d     = SLEEP;
      end

      // wake on fetch enable or any irq request, enabled or not
      SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (fetch_enable_i || irq_i.req) begin
          state_d = FIRST_FETCH;
        end
      end

      // wait for the first instruction to reach id
      FIRST_FETCH: begin
        first_fetch_o = 1'b1;
        if (id_ready_i) begin
          state_d = DECODE;
        end
        // pipe is empty here, irq wins over decode
        if (irq_pending) begin
          state_d   = IRQ_TAKEN;
          halt_if_o = 1'b1;
          halt_id_o = 1'b1;
        end
      end

      DECODE: begin
        if (instr_valid_i) begin
          is_decoding_o = 1'b1;
          unique case (ev_i)
            EV_BRANCH, EV_JUMP: begin
              // redirect happens in this cycle, keep decoding
              state_d = DECODE;
            end
            EV_ECALL, EV_ILLEGAL, EV_MRET, EV_FLUSH: begin
              // freeze if and id, trap handling next cycle
              state_d   = FLUSH;
              halt_if_o = 1'b1;
              halt_id_o = 1'b1;
            end
            default: begin
              if (irq_pending && irq_safe) begin
                state_d   = IRQ_TAKEN;
                halt_if_o = 1'b1;
                halt_id_o = 1'b1;
              end else begin
                // irq raised but masked, tell ex to drop the op
                exc_kill_o = irq_i.req & irq_safe;
              end
            end
          endcase
        end else if (irq_pending) begin
          // empty slot, take the irq straight away
          state_d   = IRQ_TAKEN;
          halt_if_o = 1'b1;
          halt_id_o = 1'b1;
        end
      end

      // single cycle, trap unit drives pc and cause
      IRQ_TAKEN: begin
        irq_ack_o = 1'b1;
        state_d   = DECODE;
      end

      // instruction held in id while the redirect is issued
      FLUSH: begin
        halt_if_o = ~fetch_enable_i;
        halt_id_o = 1'b1;
        if (!fetch_enable_i && (ev_i == EV_MRET || ev_i == EV_FLUSH)) begin
          state_d = WAIT_SLEEP;
        end else begin
          state_d = DECODE;
        end
      end

      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  // id passes through, the ack qualifies it
  assign irq_id_o = irq_i.id;

  // no register writes from bubbles or illegal encodings
  assign deassert_we_o = ~is_decoding_o | (ev_i == EV_ILLEGAL);

  assign state_o = state_q;

  //////////////////////////////
  // state register
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= RESET;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// ==== trap_ctrl.sv ====
`timescale 1ns/100ps

module trap_ctrl (
  input  ctrl_pkg::ctrl_state_e          state_i,
  input  ctrl_pkg::insn_event_e          ev_i,
  input  logic [ctrl_pkg::IRQ_ID_W-1:0]  irq_id_i,
  output trap_pkg::pc_req_t              pc_o,
  output trap_pkg::csr_ctrl_t            csr_o,
  output logic [trap_pkg::CAUSE_W-1:0]   exc_cause_o,
  output logic                           exc_ack_o
);

  import ctrl_pkg::*;
  import trap_pkg::*;

  //////////////////////////////
  // redirect and csr control
  //////////////////////////////

  always_comb begin
    // quiet defaults, no redirect and no csr update
    pc_o.set            = 1'b0;
    pc_o.mux            = PC_BOOT;
    pc_o.exc_mux        = EXC_PC_IRQ;
    csr_o.save_if       = 1'b0;
    csr_o.save_id       = 1'b0;
    csr_o.save_cause    = 1'b0;
    csr_o.restore_mret  = 1'b0;
    csr_o.cause         = '0;
    exc_cause_o         = '0;
    exc_ack_o           = 1'b0;

    unique case (state_i)
      BOOT_SET: begin
        pc_o.set = 1'b1;
        pc_o.mux = PC_BOOT;
      end

      // taken branch or jump, target comes from id
      DECODE: begin
        if (ev_i == EV_BRANCH || ev_i == EV_JUMP) begin
          pc_o.set = 1'b1;
          pc_o.mux = PC_JUMP;
        end
      end

      // interrupt entry, mepc from the if stage
      IRQ_TAKEN: begin
        pc_o.set         = 1'b1;
        pc_o.mux         = PC_EXCEPTION;
        pc_o.exc_mux     = EXC_PC_IRQ;
        exc_cause_o      = {1'b0, irq_id_i};
        csr_o.save_cause = 1'b1;
        // mcause interrupt flag in the top bit
        csr_o.cause      = {1'b1, irq_id_i};
        csr_o.save_if    = 1'b1;
        exc_ack_o        = 1'b1;
      end

      // faulting instruction still in id, mepc from there
      FLUSH: begin
        unique case (ev_i)
          EV_ECALL: begin
            pc_o.set         = 1'b1;
            pc_o.mux         = PC_EXCEPTION;
            pc_o.exc_mux     = EXC_PC_ECALL;
            csr_o.save_id    = 1'b1;
            csr_o.save_cause = 1'b1;
            csr_o.cause      = EXC_CAUSE_ECALL_MMODE;
            exc_cause_o      = EXC_CAUSE_ECALL_MMODE;
          end
          EV_ILLEGAL: begin
            pc_o.set         = 1'b1;
            pc_o.mux         = PC_EXCEPTION;
            pc_o.exc_mux     = EXC_PC_ILLINSN;
            csr_o.save_id    = 1'b1;
            csr_o.save_cause = 1'b1;
            csr_o.cause      = EXC_CAUSE_ILLEGAL_INSN;
            exc_cause_o      = EXC_CAUSE_ILLEGAL_INSN;
          end
          EV_MRET: begin
            pc_o.set           = 1'b1;
            pc_o.mux           = PC_ERET;
            csr_o.restore_mret = 1'b1;
          end
          // pipe flush only refetches, no redirect
          default: begin
            pc_o.set = 1'b0;
          end
        endcase
      end

      default: begin
        pc_o.set = 1'b0;
      end
    endcase
  end

endmodule

// ==== zr_controller.sv ====
`timescale 1ns/100ps

module zr_controller (
  input  logic                           clk,
  input  logic                           rst_n,

  input  logic                           fetch_enable_i,
  input  ctrl_pkg::insn_flags_t          insn_i,
  input  ctrl_pkg::irq_req_t             irq_i,
  input  logic                           m_ie_i,
  input  logic                           id_ready_i,

  // status
  output logic                           ctrl_busy_o,
  output logic                           instr_req_o,
  output logic                           first_fetch_o,
  output logic                           is_decoding_o,
  output logic                           deassert_we_o,

  // stalls
  output logic                           halt_if_o,
  output logic                           halt_id_o,

  // interrupt and exception handshake
  output logic                           irq_ack_o,
  output logic [ctrl_pkg::IRQ_ID_W-1:0]  irq_id_o,
  output logic [trap_pkg::CAUSE_W-1:0]   exc_cause_o,
  output logic                           exc_ack_o,
  output logic                           exc_kill_o,

  // fetch redirect and csr control
  output trap_pkg::pc_req_t              pc_o,
  output trap_pkg::csr_ctrl_t            csr_o
);

  import ctrl_pkg::*;

  insn_event_e ev;
  ctrl_state_e state;

  //////////////////////////////
  // decoder flags to event
  //////////////////////////////

  insn_event_sel u_event_sel (
    .insn_i (insn_i),
    .ev_o   (ev)
  );

  //////////////////////////////
  // state machine
  //////////////////////////////

  ctrl_fsm u_fsm (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_enable_i (fetch_enable_i),
    .id_ready_i     (id_ready_i),
    .m_ie_i         (m_ie_i),
    .instr_valid_i  (insn_i.valid),
    .ev_i           (ev),
    .irq_i          (irq_i),
    .branch_in_id_i (insn_i.branch_in_id),
    .multicycle_i   (insn_i.multicycle),
    .state_o        (state),
    .ctrl_busy_o    (ctrl_busy_o),
    .instr_req_o    (instr_req_o),
    .first_fetch_o  (first_fetch_o),
    .is_decoding_o  (is_decoding_o),
    .halt_if_o      (halt_if_o),
    .halt_id_o      (halt_id_o),
    .deassert_we_o  (deassert_we_o),
    .irq_ack_o      (irq_ack_o),
    .exc_kill_o     (exc_kill_o),
    .irq_id_o       (irq_id_o)
  );

  //////////////////////////////
  // pc and csr side
  //////////////////////////////

  trap_ctrl u_trap (
    .state_i     (state),
    .ev_i        (ev),
    .irq_id_i    (irq_i.id),
    .pc_o        (pc_o),
    .csr_o       (csr_o),
    .exc_cause_o (exc_cause_o),
    .exc_ack_o   (exc_ack_o)
  );

endmodule

// ==== tb_checks.sv ====
`timescale 1ns/100ps

module tb_checks #(
  parameter int unsigned MAX_CYCLES = 1000
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          fetch_enable_i,
  input  logic                          m_ie_i,
  input  ctrl_pkg::insn_flags_t         insn_i,
  input  ctrl_pkg::irq_req_t            irq_i,
  // stimulus side knows when the controller sits in DECODE or SLEEP
  input  logic                          in_decode_i,
  input  logic                          in_sleep_i,
  input  logic                          ctrl_busy_i,
  input  logic                          instr_req_i,
  input  logic                          first_fetch_i,
  input  logic                          is_decoding_i,
  input  logic                          halt_if_i,
  input  logic                          halt_id_i,
  input  logic                          deassert_we_i,
  input  logic                          irq_ack_i,
  input  logic [ctrl_pkg::IRQ_ID_W-1:0] irq_id_i,
  input  logic [trap_pkg::CAUSE_W-1:0]  exc_cause_i,
  input  logic                          exc_ack_i,
  input  logic                          exc_kill_i,
  input  trap_pkg::pc_req_t             pc_i,
  input  trap_pkg::csr_ctrl_t           csr_i,
  output logic                          fail_o
);

  import ctrl_pkg::*;
  import trap_pkg::*;

  logic                check_failed = 1'b0;
  logic                timed_out = 1'b0;
  int unsigned         cycles = 0;
  logic                seen_fe;
  logic [IRQ_ID_W-1:0] irq_id_q;

  // expected event per instruction in priority order
  logic ev_jump;
  logic ev_ecall;
  logic ev_illegal;
  logic ev_mret;
  logic ev_plain;

  assign ev_jump    = insn_i.valid & (insn_i.branch_set | insn_i.jump_set);
  assign ev_ecall   = insn_i.valid & ~ev_jump & insn_i.ecall;
  assign ev_illegal = insn_i.valid & ~ev_jump & ~insn_i.ecall & insn_i.illegal;
  assign ev_mret    = insn_i.valid & ~ev_jump & ~insn_i.ecall & ~insn_i.illegal &
                      insn_i.mret;
  // valid instruction with no special flag at all
  assign ev_plain   = insn_i.valid & ~(insn_i.branch_set | insn_i.jump_set | insn_i.ecall |
                      insn_i.illegal | insn_i.mret | insn_i.pipe_flush);

  assign fail_o = check_failed | timed_out;

  task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] got_val);
    $display("ERROR at %0t: %s expected %0h got %0h", $time, name, exp_val, got_val);
    check_failed = 1'b1;
  endtask

  //////////////////////////////
  // bookkeeping
  //////////////////////////////

  // first fetch enable after reset starts the boot
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seen_fe <= 1'b0;
    end else if (fetch_enable_i) begin
      seen_fe <= 1'b1;
    end
  end

  // irq id of the request cycle for the compare in the ack cycle
  always @(posedge clk) begin
    irq_id_q <= irq_i.id;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES && !timed_out) begin
      $display("timeout: stimulus did not finish within %0d cycles", MAX_CYCLES);
      timed_out <= 1'b1;
    end
  end

  //////////////////////////////
  // boot
  //////////////////////////////

  chk_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !seen_fe |-> {ctrl_busy_i, instr_req_i, pc_i.set} == 3'b000)
    else report_mismatch("ctrl_busy_o/instr_req_o/pc_o.set", 32'h0,
                         $sampled({ctrl_busy_i, instr_req_i, pc_i.set}));

  // boot pc loaded one cycle after fetch enable is seen
  chk_boot: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_enable_i && !seen_fe |=>
    {pc_i.set, pc_i.mux, ctrl_busy_i} == {1'b1, PC_BOOT, 1'b1})
    else report_mismatch("pc_o.set/mux/ctrl_busy_o", {1'b1, PC_BOOT, 1'b1},
                         $sampled({pc_i.set, pc_i.mux, ctrl_busy_i}));

  //////////////////////////////
  // decode events
  //////////////////////////////

  // a valid instruction in DECODE is being decoded
  chk_decoding: assert property (@(posedge clk) disable iff (!rst_n)
    in_decode_i && insn_i.valid |-> is_decoding_i)
    else report_mismatch("is_decoding_o", 32'h1, $sampled(is_decoding_i));

  // redirect in the decode cycle itself with no halt
  chk_jump: assert property (@(posedge clk) disable iff (!rst_n)
    in_decode_i && ev_jump |->
    {pc_i.set, pc_i.mux, halt_if_i, halt_id_i} == {1'b1, PC_JUMP, 2'b00})
    else report_mismatch("pc_o.set/mux/halt_if_o/halt_id_o", {1'b1, PC_JUMP, 2'b00},
                         $sampled({pc_i.set, pc_i.mux, halt_if_i, halt_id_i}));

  // pipe frozen while the trap is decoded
  chk_trap_halt: assert property (@(posedge clk) disable iff (!rst_n)
    in_decode_i && (ev_ecall || ev_illegal) |-> {halt_if_i, halt_id_i} == 2'b11)
    else report_mismatch("halt_if_o/halt_id_o", 32'h3, $sampled({halt_if_i, halt_id_i}));

  chk_illegal_we: assert property (@(posedge clk) disable iff (!rst_n)
    in_decode_i && ev_illegal |-> deassert_we_i)
    else report_mismatch("deassert_we_o", 32'h1, $sampled(deassert_we_i));

  // traps load the vector and save mepc and cause from id
  chk_ecall: assert property (@(posedge clk) disable iff (!rst_n)
    in_decode_i && ev_ecall |=>
    {pc_i.set, pc_i.mux, pc_i.exc_mux, csr_i.save_cause, csr_i.save_id, csr_i.cause,
     exc_cause_i} == {1'b1, PC_EXCEPTION, EXC_PC_ECALL, 2'b11, 6'd11, 6'd11})
    else report_mismatch("pc_o/csr_o/exc_cause_o ecall",
                         {1'b1, PC_EXCEPTION, EXC_PC_ECALL, 2'b11, 6'd11, 6'd11},
                         $sampled({pc_i.set, pc_i.mux, pc_i.exc_mux, csr_i.save_cause,
                         csr_i.save_id, csr_i.cause, exc_cause_i}));

  chk_illegal: assert property (@(posedge clk) disable iff (!rst_n)
    in_decode_i && ev_illegal |=>
    {pc_i.set, pc_i.mux, pc_i.exc_mux, csr_i.save_cause, csr_i.save_id, csr_i.cause,
     exc_cause_i} == {1'b1, PC_EXCEPTION, EXC_PC_ILLINSN, 2'b11, 6'd2, 6'd2})
    else report_mismatch("pc_o/csr_o/exc_cause_o illegal",
                         {1'b1, PC_EXCEPTION, EXC_PC_ILLINSN, 2'b11, 6'd2, 6'd2},
                         $sampled({pc_i.set, pc_i.mux, pc_i.exc_mux, csr_i.save_cause,
                         csr_i.save_id, csr_i.cause, exc_cause_i}));

  chk_mret: assert property (@(posedge clk) disable iff (!rst_n)
    in_decode_i && ev_mret |=>
    {pc_i.set, pc_i.mux, csr_i.restore_mret} == {1'b1, PC_ERET, 1'b1})
    else report_mismatch("pc_o.set/mux/csr_o.restore_mret", {1'b1, PC_ERET, 1'b1},
                         $sampled({pc_i.set, pc_i.mux, csr_i.restore_mret}));

  // mret with fetch disabled drains into sleep
  chk_mret_sleep: assert property (@(posedge clk) disable iff (!rst_n)
    in_decode_i && ev_mret ##1 !fetch_enable_i |=> {ctrl_busy_i, halt_if_i, halt_id_i} == 3'b011)
    else report_mismatch("ctrl_busy_o/halt_if_o/halt_id_o", 32'h3,
                         $sampled({ctrl_busy_i, halt_if_i, halt_id_i}));

  //////////////////////////////
  // interrupts and sleep
  //////////////////////////////

  // ack and id plus mcause with the interrupt bit on top
  chk_irq: assert property (@(posedge clk) disable iff (!rst_n)
    in_decode_i && !insn_i.valid && irq_i.req && m_ie_i |=>
    {irq_ack_i, irq_id_i, csr_i.save_if, csr_i.cause} == {1'b1, irq_id_q, 2'b11, irq_id_q})
    else report_mismatch("irq_ack_o/irq_id_o/csr_o.save_if/cause",
                         {1'b1, $sampled(irq_id_q), 2'b11, $sampled(irq_id_q)},
                         $sampled({irq_ack_i, irq_id_i, csr_i.save_if, csr_i.cause}));

  // exception handshake carries the interrupt id
  chk_irq_exc: assert property (@(posedge clk) disable iff (!rst_n)
    in_decode_i && !insn_i.valid && irq_i.req && m_ie_i |=>
    {exc_ack_i, exc_cause_i[IRQ_ID_W-1:0]} == {1'b1, irq_id_q})
    else report_mismatch("exc_ack_o/exc_cause_o", {1'b1, $sampled(irq_id_q)},
                         $sampled({exc_ack_i, exc_cause_i[IRQ_ID_W-1:0]}));

  chk_kill: assert property (@(posedge clk) disable iff (!rst_n)
    in_decode_i && ev_plain && !insn_i.multicycle && !insn_i.branch_in_id &&
    irq_i.req && !m_ie_i |-> exc_kill_i)
    else report_mismatch("exc_kill_o", 32'h1, $sampled(exc_kill_i));

  // masked request must never be acknowledged
  chk_kill_no_ack: assert property (@(posedge clk) disable iff (!rst_n)
    in_decode_i && ev_plain && irq_i.req && !m_ie_i |=> !irq_ack_i)
    else report_mismatch("irq_ack_o", 32'h0, $sampled(irq_ack_i));

  chk_wake: assert property (@(posedge clk) disable iff (!rst_n)
    in_sleep_i && irq_i.req |=> first_fetch_i)
    else report_mismatch("first_fetch_o", 32'h1, $sampled(first_fetch_i));

endmodule

// ==== tb_controller.sv ====
`timescale 1ns/100ps

module tb_controller;

  import ctrl_pkg::*;
  import trap_pkg::*;

  // directed part plus the longest random step for every loop
  localparam int unsigned N_RAND      = 40;
  localparam int unsigned STIM_CYCLES = 40 + N_RAND * 5;

  logic        clk;
  logic        rst_n;
  logic        fetch_enable;
  logic        id_ready;
  logic        m_ie;
  insn_flags_t insn;
  irq_req_t    irq;
  logic        in_decode;
  logic        in_sleep;
  logic        run_failed;
  logic [31:0] seed;

  logic                ctrl_busy;
  logic                instr_req;
  logic                first_fetch;
  logic                is_decoding;
  logic                deassert_we;
  logic                halt_if;
  logic                halt_id;
  logic                irq_ack;
  logic [IRQ_ID_W-1:0] irq_id;
  logic [CAUSE_W-1:0]  exc_cause;
  logic                exc_ack;
  logic                exc_kill;
  pc_req_t             pc;
  csr_ctrl_t           csr;

  zr_controller dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_enable_i (fetch_enable),
    .insn_i         (insn),
    .irq_i          (irq),
    .m_ie_i         (m_ie),
    .id_ready_i     (id_ready),
    .ctrl_busy_o    (ctrl_busy),
    .instr_req_o    (instr_req),
    .first_fetch_o  (first_fetch),
    .is_decoding_o  (is_decoding),
    .deassert_we_o  (deassert_we),
    .halt_if_o      (halt_if),
    .halt_id_o      (halt_id),
    .irq_ack_o      (irq_ack),
    .irq_id_o       (irq_id),
    .exc_cause_o    (exc_cause),
    .exc_ack_o      (exc_ack),
    .exc_kill_o     (exc_kill),
    .pc_o           (pc),
    .csr_o          (csr)
  );

  tb_checks #(
    .MAX_CYCLES (4 * STIM_CYCLES)
  ) u_checks (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_enable_i (fetch_enable),
    .m_ie_i         (m_ie),
    .insn_i         (insn),
    .irq_i          (irq),
    .in_decode_i    (in_decode),
    .in_sleep_i     (in_sleep),
    .ctrl_busy_i    (ctrl_busy),
    .instr_req_i    (instr_req),
    .first_fetch_i  (first_fetch),
    .is_decoding_i  (is_decoding),
    .halt_if_i      (halt_if),
    .halt_id_i      (halt_id),
    .deassert_we_i  (deassert_we),
    .irq_ack_i      (irq_ack),
    .irq_id_i       (irq_id),
    .exc_cause_i    (exc_cause),
    .exc_ack_i      (exc_ack),
    .exc_kill_i     (exc_kill),
    .pc_i           (pc),
    .csr_i          (csr),
    .fail_o         (run_failed)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  //////////////////////////////
  // stimulus steps
  //////////////////////////////

  // returns once FIRST_FETCH has passed with id_ready high
  task automatic wait_for_decode();
    while (!first_fetch) begin
      @(negedge clk);
    end
    @(negedge clk);
  endtask

  task automatic issue_redirect(input logic is_branch);
    seed            = lcg_step(seed);
    insn            = '0;
    insn.valid      = 1'b1;
    insn.branch_set = is_branch;
    insn.jump_set   = ~is_branch;
    // lower priority flags ride along at random
    insn.ecall      = seed[16];
    insn.illegal    = seed[17];
    insn.mret       = seed[18];
    in_decode       = 1'b1;
    @(negedge clk);
    insn      = '0;
    in_decode = 1'b0;
  endtask

  task automatic raise_trap(input insn_event_e ev, input logic stay_awake);
    seed            = lcg_step(seed);
    insn            = '0;
    insn.valid      = 1'b1;
    insn.ecall      = (ev == EV_ECALL);
    insn.illegal    = (ev == EV_ILLEGAL) | ((ev == EV_ECALL) & seed[16]);
    insn.mret       = (ev == EV_MRET) | ((ev != EV_MRET) & seed[17]);
    insn.pipe_flush = seed[18];
    in_decode       = 1'b1;
    @(negedge clk);
    // instruction stays in id through FLUSH
    in_decode    = 1'b0;
    fetch_enable = stay_awake;
    @(negedge clk);
    insn = '0;
  endtask

  task automatic take_irq(input logic [IRQ_ID_W-1:0] id);
    m_ie      = 1'b1;
    irq.req   = 1'b1;
    irq.id    = id;
    in_decode = 1'b1;
    @(negedge clk);
    // id held on the bus for the ack cycle
    irq.req   = 1'b0;
    in_decode = 1'b0;
    @(negedge clk);
    irq  = '0;
    m_ie = 1'b0;
  endtask

  // plain instruction in id while the request is masked
  task automatic mask_irq(input logic [IRQ_ID_W-1:0] id);
    insn       = '0;
    insn.valid = 1'b1;
    irq.req    = 1'b1;
    irq.id     = id;
    m_ie       = 1'b0;
    in_decode  = 1'b1;
    @(negedge clk);
    insn      = '0;
    irq       = '0;
    in_decode = 1'b0;
  endtask

  task automatic sleep_and_wake(input logic [IRQ_ID_W-1:0] id);
    raise_trap(EV_MRET, 1'b0);
    // WAIT_SLEEP passes before SLEEP
    @(negedge clk);
    in_sleep = 1'b1;
    irq.req  = 1'b1;
    irq.id   = id;
    @(negedge clk);
    in_sleep     = 1'b0;
    irq          = '0;
    fetch_enable = 1'b1;
    wait_for_decode();
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    logic [2:0]          pick;
    logic [IRQ_ID_W-1:0] rid;

    rst_n        = 1'b0;
    fetch_enable = 1'b0;
    id_ready     = 1'b1;
    m_ie         = 1'b0;
    insn         = '0;
    irq          = '0;
    in_decode    = 1'b0;
    in_sleep     = 1'b0;
    seed         = 32'h11748a92;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    // idle with fetch disabled before the boot
    repeat (3) @(negedge clk);
    fetch_enable = 1'b1;
    wait_for_decode();

    issue_redirect(1'b1);
    issue_redirect(1'b0);
    raise_trap(EV_ECALL, 1'b1);
    raise_trap(EV_ILLEGAL, 1'b1);
    raise_trap(EV_MRET, 1'b1);
    take_irq(5'd3);
    mask_irq(5'd7);
    sleep_and_wake(5'd12);

    // upper lcg bits pick the random step
    for (int i = 0; i < N_RAND; i++) begin
      seed = lcg_step(seed);
      pick = seed[31:29];
      rid  = seed[20:16];
      case (pick)
        3'd0: issue_redirect(1'b1);
        3'd1: issue_redirect(1'b0);
        3'd2: raise_trap(EV_ECALL, 1'b1);
        3'd3: raise_trap(EV_ILLEGAL, 1'b1);
        3'd4: raise_trap(EV_MRET, 1'b1);
        3'd5: take_irq(rid);
        3'd6: mask_irq(rid);
        default: sleep_and_wake(rid);
      endcase
    end

    @(negedge clk);
    if (run_failed) begin
      $display("Result: FAILED");
      $fatal(1, "checks failed");
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

  // first error or timeout ends the run
  initial begin
    @(posedge run_failed);
    $display("Result: FAILED");
    $fatal(1, "stopped at first error");
  end

endmodule

// ==== files.f ====
ctrl_pkg.sv
trap_pkg.sv
insn_event_sel.sv
ctrl_fsm.sv
trap_ctrl.sv
zr_controller.sv
tb_checks.sv
tb_controller.sv

// ==== Bender.yml ====
package:
  name: zr_controller

sources:
  - ctrl_pkg.sv
  - trap_pkg.sv
  - insn_event_sel.sv
  - ctrl_fsm.sv
  - trap_ctrl.sv
  - zr_controller.sv
  - target: test
    files:
      - tb_checks.sv
      - tb_controller.sv
